// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = icache_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Output goes to the console, the status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/icache_fill_if.sv ====
// Miss request and line fill link between lookup and memory controller

`default_nettype none

interface icache_fill_if;

    // Miss request, valid/ready, line aligned address
    logic                             miss_valid;
    logic                             miss_ready;
    logic [icache_pkg::addr_w-1:0]    miss_addr;

    // Line write, one cycle pulse, also closes the miss
    logic                             fill_wen;
    logic [icache_pkg::index_w-1:0]   fill_index;
    logic [icache_pkg::line_w-1:0]    fill_data;
    logic [1:0]                       fill_resp;

    // High while the eraser walks the lines
    logic                             flushing;

    modport lookup (
        output miss_valid,
        output miss_addr,
        input  miss_ready,
        input  fill_wen,
        input  fill_index,
        input  fill_data,
        input  fill_resp,
        input  flushing
    );

    modport memctrl (
        input  miss_valid,
        input  miss_addr,
        output miss_ready,
        output fill_wen,
        output fill_index,
        output fill_data,
        output fill_resp,
        output flushing
    );

endinterface

`default_nettype wire

// ==== design/icache_lookup.sv ====
// Instruction cache lookup with tag, valid and data arrays
// Serves one fetch at a time on an AXI4-Lite read slave port

`default_nettype none

module icache_lookup (
    input  wire                             aclk,
    input  wire                             aresetn,
    // Fetch read address channel
    input  wire                             arvalid,
    output logic                            arready,
    input  wire  [icache_pkg::addr_w-1:0]   araddr,
    input  wire  [2:0]                      arprot,
    // Fetch read data channel
    output logic                            rvalid,
    input  wire                             rready,
    output logic [icache_pkg::word_w-1:0]   rdata,
    output logic [1:0]                      rresp,
    // Towards the memory controller
    icache_fill_if.lookup                   fill
);

    ////////////////////////////////////////////////////////////
    // Signals
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        st_idle,
        st_cmp,
        st_miss,
        st_resp
    } lookup_state_t;

    lookup_state_t state;

    // Goes high one cycle after reset release
    logic ar_en;

    // Fetch address of the request in progress
    icache_pkg::icache_addr_u addr_q;

    // Cache storage
    logic [icache_pkg::depth-1:0]  valid;
    logic [icache_pkg::tag_w-1:0]  tag_mem  [icache_pkg::depth];
    logic [icache_pkg::line_w-1:0] data_mem [icache_pkg::depth];

    logic                          hit;
    logic [icache_pkg::line_w-1:0] hit_line;
    logic [1:0]                    word_sel;

    ////////////////////////////////////////////////////////////
    // Address channel and tag compare
    ////////////////////////////////////////////////////////////

    // Only accept when idle, never during an erase
    assign arready = ar_en && (state == st_idle) && !fill.flushing;

    assign hit_line = data_mem[addr_q.f.index];
    assign hit = valid[addr_q.f.index] && (tag_mem[addr_q.f.index] == addr_q.f.tag);

    // Word within the line, offset bits 3:2
    assign word_sel = addr_q.f.offset[3:2];

    // Miss goes out as the raw address with the offset cleared
    assign fill.miss_addr = {addr_q.raw[icache_pkg::addr_w-1:icache_pkg::offset_w],
                             {icache_pkg::offset_w{1'b0}}};

    ////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state           <= st_idle;
            ar_en           <= 1'b0;
            rvalid          <= 1'b0;
            fill.miss_valid <= 1'b0;
        end else begin
            ar_en <= 1'b1;
            case (state)
                st_idle: begin
                    if (arvalid && arready) begin
                        state <= st_cmp;
                    end
                end
                st_cmp: begin
                    // Hold off while the lines are being erased
                    if (!fill.flushing) begin
                        if (hit) begin
                            rvalid <= 1'b1;
                            state  <= st_resp;
                        end else begin
                            fill.miss_valid <= 1'b1;
                            state           <= st_miss;
                        end
                    end
                end
                st_miss: begin
                    if (fill.miss_valid && fill.miss_ready) begin
                        fill.miss_valid <= 1'b0;
                    end
                    // Refill pulse ends the miss, error or not
                    if (fill.fill_wen && !fill.flushing) begin
                        rvalid <= 1'b1;
                        state  <= st_resp;
                    end
                end
                default: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
            endcase
        end
    end

    // Address and response payload
    always_ff @(posedge aclk) begin
        if (arvalid && arready) begin
            addr_q.raw <= araddr;
        end
        if (state == st_cmp && !fill.flushing && hit) begin
            rdata <= hit_line[word_sel*icache_pkg::word_w +: icache_pkg::word_w];
            rresp <= icache_pkg::resp_okay;
        end else if (state == st_miss && fill.fill_wen && !fill.flushing) begin
            rdata <= fill.fill_data[word_sel*icache_pkg::word_w +: icache_pkg::word_w];
            rresp <= fill.fill_resp;
        end
    end

    ////////////////////////////////////////////////////////////
    // Array write, refill or erase
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= '0;
        end else if (fill.fill_wen) begin
            if (fill.flushing) begin
                valid[fill.fill_index] <= 1'b0;
            end else if (fill.fill_resp == icache_pkg::resp_okay) begin
                valid[fill.fill_index] <= 1'b1;
            end
        end
    end

    // Tag and data follow the valid bit, errors leave the line alone
    always_ff @(posedge aclk) begin
        if (fill.fill_wen && (fill.flushing || fill.fill_resp == icache_pkg::resp_okay)) begin
            tag_mem[fill.fill_index]  <= addr_q.f.tag;
            data_mem[fill.fill_index] <= fill.fill_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Response held under back-pressure
    assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    // Erase and new fetches never overlap
    assert property (@(posedge aclk) disable iff (!aresetn)
        fill.flushing |-> !arready);

    // Fetch side keeps its request steady until taken
    assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arprot));

endmodule

`default_nettype wire

// ==== design/icache_memctrl.sv ====
// Instruction cache memory controller
// Line refill over an AXI4-Lite read master and the flush eraser

`default_nettype none

module icache_memctrl (
    input  wire                             aclk,
    input  wire                             aresetn,
    // Central memory read address channel
    output logic                            mem_arvalid,
    input  wire                             mem_arready,
    output logic [icache_pkg::addr_w-1:0]   mem_araddr,
    output logic [2:0]                      mem_arprot,
    // Central memory read data channel
    input  wire                             mem_rvalid,
    output logic                            mem_rready,
    input  wire  [icache_pkg::line_w-1:0]   mem_rdata,
    input  wire  [1:0]                      mem_rresp,
    // FENCE.i style flush handshake
    input  wire                             flush_req,
    output logic                            flush_ack,
    // Towards the lookup
    icache_fill_if.memctrl                  fill
);

    ////////////////////////////////////////////////////////////
    // Signals
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        st_idle,
        st_erase,
        st_ack
    } flush_state_t;

    flush_state_t state;

    logic [icache_pkg::index_w-1:0] erase_idx;

    // One read in flight on the memory port
    logic pending;

    // Refill captured from the R channel
    logic                           refill_wen;
    logic [icache_pkg::index_w-1:0] refill_index;
    logic [icache_pkg::index_w-1:0] miss_index;
    logic [icache_pkg::line_w-1:0]  refill_data;
    logic [1:0]                     refill_resp;

    ////////////////////////////////////////////////////////////
    // Read address channel, miss passed straight through
    ////////////////////////////////////////////////////////////

    // A miss raised during erase waits for the eraser
    assign mem_arvalid     = fill.miss_valid && (state != st_erase);
    assign fill.miss_ready = mem_arready && (state != st_erase);
    assign mem_araddr      = fill.miss_addr;

    // Unprivileged, secure, instruction access
    assign mem_arprot = 3'b100;

    assign miss_index = fill.miss_addr[icache_pkg::offset_w +: icache_pkg::index_w];

    // Data accepted only while the refill is outstanding
    assign mem_rready = pending;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pending    <= 1'b0;
            refill_wen <= 1'b0;
        end else begin
            refill_wen <= mem_rvalid && mem_rready;
            if (mem_arvalid && mem_arready) begin
                pending <= 1'b1;
            end else if (mem_rvalid && mem_rready) begin
                pending <= 1'b0;
            end
        end
    end

    // Line index kept from the AR handshake, line from the R handshake
    always_ff @(posedge aclk) begin
        if (mem_arvalid && mem_arready) begin
            refill_index <= miss_index;
        end
        if (mem_rvalid && mem_rready) begin
            refill_data <= mem_rdata;
            refill_resp <= mem_rresp;
        end
    end

    ////////////////////////////////////////////////////////////
    // Line write mux, erase has zero data and no valid
    ////////////////////////////////////////////////////////////

    assign fill.flushing   = (state == st_erase);
    assign fill.fill_wen   = refill_wen || fill.flushing;
    assign fill.fill_index = fill.flushing ? erase_idx : refill_index;
    assign fill.fill_data  = fill.flushing ? '0 : refill_data;
    assign fill.fill_resp  = fill.flushing ? icache_pkg::resp_okay : refill_resp;

    ////////////////////////////////////////////////////////////
    // Flush FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= st_idle;
            erase_idx <= '0;
            flush_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // Start only with no miss in flight
                    if (flush_req && !fill.miss_valid && !pending) begin
                        erase_idx <= '0;
                        state     <= st_erase;
                    end
                end
                st_erase: begin
                    erase_idx <= erase_idx + 1'b1;
                    if (erase_idx == icache_pkg::index_w'(icache_pkg::depth - 1)) begin
                        flush_ack <= 1'b1;
                        state     <= st_ack;
                    end
                end
                default: begin
                    // Ack holds until the requester lets go
                    if (!flush_req) begin
                        flush_ack <= 1'b0;
                        state     <= st_idle;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Erase never collides with a refill write
    assert property (@(posedge aclk) disable iff (!aresetn)
        (state == st_erase) |-> !refill_wen);

    // Lookup must hand over line aligned misses
    assert property (@(posedge aclk) disable iff (!aresetn)
        mem_arvalid |-> (mem_araddr[icache_pkg::offset_w-1:0] == '0));

endmodule

`default_nettype wire

// ==== design/icache_pkg.sv ====
// Instruction cache shared definitions
// Geometry, fetch address layout and AXI response codes

`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////

    // Byte address width on both AXI ports
    localparam int addr_w   = 16;
    // Line payload and instruction word
    localparam int line_w   = 128;
    localparam int word_w   = 32;
    // Direct mapped, one line per index
    localparam int depth    = 64;
    localparam int offset_w = 4;
    localparam int index_w  = 6;
    localparam int tag_w    = addr_w - index_w - offset_w;

    ////////////////////////////////////////////////////////////
    // Fetch address, seen raw or split into fields
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } icache_addr_s;

    typedef union packed {
        logic [addr_w-1:0] raw;
        icache_addr_s      f;
    } icache_addr_u;

    // AXI read responses in use
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== design/icache_top.sv ====
// Instruction cache top level
// Lookup and memory controller joined by the fill interface

`default_nettype none

module icache_top (
    input  wire                             aclk,
    input  wire                             aresetn,
    // Fetch AXI4-Lite read slave
    input  wire                             arvalid,
    output logic                            arready,
    input  wire  [icache_pkg::addr_w-1:0]   araddr,
    input  wire  [2:0]                      arprot,
    output logic                            rvalid,
    input  wire                             rready,
    output logic [icache_pkg::word_w-1:0]   rdata,
    output logic [1:0]                      rresp,
    // Central memory AXI4-Lite read master
    output logic                            mem_arvalid,
    input  wire                             mem_arready,
    output logic [icache_pkg::addr_w-1:0]   mem_araddr,
    output logic [2:0]                      mem_arprot,
    input  wire                             mem_rvalid,
    output logic                            mem_rready,
    input  wire  [icache_pkg::line_w-1:0]   mem_rdata,
    input  wire  [1:0]                      mem_rresp,
    // Flush handshake
    input  wire                             flush_req,
    output logic                            flush_ack
);

    // Miss, refill and erase traffic
    icache_fill_if fill ();

    ////////////////////////////////////////////////////////////
    // Tag compare and word select
    ////////////////////////////////////////////////////////////

    icache_lookup u_lookup (
        .aclk    (aclk),
        .aresetn (aresetn),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .fill    (fill.lookup)
    );

    ////////////////////////////////////////////////////////////
    // Refill and flush
    ////////////////////////////////////////////////////////////

    icache_memctrl u_memctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_arprot  (mem_arprot),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .flush_req   (flush_req),
        .flush_ack   (flush_ack),
        .fill        (fill.memctrl)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
design/icache_pkg.sv
design/icache_fill_if.sv
design/icache_lookup.sv
design/icache_memctrl.sv
design/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

// ==== sim/icache_mem_model.sv ====
// Central memory model for instruction cache line refills
// Random latency, generation tagged line data and an error window

`default_nettype none

module icache_mem_model (
    input  wire          aclk,
    input  wire          aresetn,
    // AXI4-Lite read address channel
    input  wire          mem_arvalid,
    output logic         mem_arready,
    input  wire  [15:0]  mem_araddr,
    // AXI4-Lite read data channel
    output logic         mem_rvalid,
    input  wire          mem_rready,
    output logic [127:0] mem_rdata,
    output logic [1:0]   mem_rresp,
    // Top byte of every returned word
    input  wire  [7:0]   generation
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] line_addr;
    logic        busy;
    int          wait_cnt;

    // Word k holds the generation, then the byte address of that word
    function automatic logic [127:0] line_pattern(input logic [15:0] addr,
                                                  input logic [7:0] gen);
        logic [127:0] line;
        logic [15:0]  word_addr;
        for (int k = 0; k < 4; k++) begin
            word_addr = addr + 16'(4 * k);
            line[k*32 +: 32] = {gen, 8'h00, word_addr};
        end
        return line;
    endfunction

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mem_arready <= 1'b0;
            mem_rvalid  <= 1'b0;
            mem_rdata   <= '0;
            mem_rresp   <= 2'b00;
            line_addr   <= '0;
            busy        <= 1'b0;
            wait_cnt    <= 0;
        end else if (!busy) begin
            mem_arready <= 1'b1;
            if (mem_arvalid && mem_arready) begin
                line_addr   <= mem_araddr;
                mem_arready <= 1'b0;
                busy        <= 1'b1;
                // Between 1 and 6 cycles to the data
                wait_cnt    <= int'($urandom % 6) + 1;
            end
        end else if (!mem_rvalid) begin
            if (wait_cnt == 1) begin
                mem_rvalid <= 1'b1;
                // Addresses F000 to F0FF answer with slverr and no data
                if (line_addr[15:8] == 8'hF0) begin
                    mem_rdata <= '0;
                    mem_rresp <= 2'b10;
                end else begin
                    mem_rdata <= line_pattern(line_addr, generation);
                    mem_rresp <= 2'b00;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_rready) begin
            mem_rvalid <= 1'b0;
            busy       <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
// Instruction cache testbench
// Table driven fetches and flushes against a random latency memory

`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] okay   = 2'b00;
    localparam logic [1:0] slverr = 2'b10;

    typedef enum logic {
        op_fetch,
        op_flush
    } op_t;

    // One table row, memory generation applied before the row
    typedef struct packed {
        op_t         op;
        logic [7:0]  gen;
        logic [15:0] addr;
        logic [31:0] word;
        logic [1:0]  resp;
        logic        mem_read;
        logic [3:0]  stall;
    } row_t;

    row_t rows [$];

    logic         aclk = 1'b0;
    logic         aresetn;
    logic         arvalid;
    logic         arready;
    logic [15:0]  araddr;
    logic [2:0]   arprot;
    logic         rvalid;
    logic         rready;
    logic [31:0]  rdata;
    logic [1:0]   rresp;
    logic         mem_arvalid;
    logic         mem_arready;
    logic [15:0]  mem_araddr;
    logic [2:0]   mem_arprot;
    logic         mem_rvalid;
    logic         mem_rready;
    logic [127:0] mem_rdata;
    logic [1:0]   mem_rresp;
    logic         flush_req;
    logic         flush_ack;
    logic [7:0]   generation;

    int          errors = 0;
    int          checks = 0;
    int          mem_reads = 0;
    int unsigned seed_draw;

    // 8 ns clock
    always #4 aclk = ~aclk;

    icache_top u_icache_top (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arprot      (arprot),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_arprot  (mem_arprot),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .flush_req   (flush_req),
        .flush_ack   (flush_ack)
    );

    icache_mem_model u_mem_model (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .generation  (generation)
    );

    // Memory reads seen at the top ports tell hit from miss
    always @(posedge aclk) begin
        if (mem_arvalid && mem_arready) begin
            mem_reads <= mem_reads + 1;
            // Line reads are unprivileged instruction accesses
            compare("mem_arprot on a line read", mem_arprot, 3'b100);
        end
    end

    ////////////////////////////////////////////////////////////
    // Table and helpers
    ////////////////////////////////////////////////////////////

    task automatic add_row(input op_t op, input logic [7:0] gen, input logic [15:0] addr,
                           input logic [31:0] word, input logic [1:0] resp,
                           input logic mem_read, input logic [3:0] stall);
        row_t r;
        r.op       = op;
        r.gen      = gen;
        r.addr     = addr;
        r.word     = word;
        r.resp     = resp;
        r.mem_read = mem_read;
        r.stall    = stall;
        rows.push_back(r);
    endtask

    task automatic load_table();
        // Cold miss, then hits in the same line
        add_row(op_fetch, 8'h01, 16'h0120, 32'h01000120, okay, 1'b1, 4'd0);
        add_row(op_fetch, 8'h01, 16'h0128, 32'h01000128, okay, 1'b0, 4'd0);
        add_row(op_fetch, 8'h01, 16'h0120, 32'h01000120, okay, 1'b0, 4'd0);
        add_row(op_fetch, 8'h01, 16'h012C, 32'h0100012C, okay, 1'b0, 4'd0);
        // Index 12h shared by tags 0 and 1
        add_row(op_fetch, 8'h01, 16'h0524, 32'h01000524, okay, 1'b1, 4'd0);
        add_row(op_fetch, 8'h01, 16'h0120, 32'h01000120, okay, 1'b1, 4'd0);
        add_row(op_fetch, 8'h01, 16'h0524, 32'h01000524, okay, 1'b1, 4'd0);
        add_row(op_fetch, 8'h01, 16'h0528, 32'h01000528, okay, 1'b0, 4'd0);
        // Long back-pressure on rready
        add_row(op_fetch, 8'h01, 16'h0A40, 32'h01000A40, okay, 1'b1, 4'd5);
        add_row(op_fetch, 8'h01, 16'h0A4C, 32'h01000A4C, okay, 1'b0, 4'd4);
        // Error window, never cached
        add_row(op_fetch, 8'h01, 16'hF010, 32'h00000000, slverr, 1'b1, 4'd0);
        add_row(op_fetch, 8'h01, 16'hF010, 32'h00000000, slverr, 1'b1, 4'd2);
        add_row(op_fetch, 8'h01, 16'hF0FC, 32'h00000000, slverr, 1'b1, 4'd0);
        // New generation, stale line until the flush
        add_row(op_fetch, 8'h02, 16'h0A44, 32'h01000A44, okay, 1'b0, 4'd0);
        add_row(op_flush, 8'h02, 16'h0000, 32'h00000000, okay, 1'b0, 4'd0);
        add_row(op_fetch, 8'h02, 16'h0A44, 32'h02000A44, okay, 1'b1, 4'd0);
        add_row(op_fetch, 8'h02, 16'h0524, 32'h02000524, okay, 1'b1, 4'd0);
        add_row(op_fetch, 8'h02, 16'h0A48, 32'h02000A48, okay, 1'b0, 4'd0);
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Fetch and flush sequences
    ////////////////////////////////////////////////////////////

    task automatic run_fetch(input row_t row);
        int          reads_before;
        int          rise;
        int          hold;
        logic [31:0] data_q;
        logic [1:0]  resp_q;

        reads_before = mem_reads;
        hold = int'(row.stall) + int'($urandom % 4);
        @(posedge aclk);
        arvalid <= 1'b1;
        araddr  <= row.addr;
        arprot  <= 3'b100;
        // Address handshake
        do begin
            @(posedge aclk);
        end while (!arready);
        arvalid <= 1'b0;
        // Edges from acceptance until rvalid is seen
        rise = 0;
        do begin
            @(posedge aclk);
            rise++;
        end while (!rvalid);
        if (!row.mem_read) begin
            compare("hit latency in cycles", rise - 1, 1);
        end
        data_q = rdata;
        resp_q = rresp;
        // Response must hold while rready is low
        repeat (hold) begin
            @(posedge aclk);
            compare("rvalid under back-pressure", rvalid, 1);
            compare("rdata under back-pressure", rdata, data_q);
            compare("rresp under back-pressure", rresp, resp_q);
            compare("arready while a response waits", arready, 0);
        end
        rready <= 1'b1;
        @(posedge aclk);
        compare("rvalid at the handshake", rvalid, 1);
        compare("rdata at the handshake", rdata, data_q);
        rready <= 1'b0;
        compare("response code", resp_q, row.resp);
        if (row.resp == okay) begin
            compare("instruction word", data_q, row.word);
        end
        compare("memory reads for the fetch", mem_reads - reads_before, row.mem_read);
    endtask

    task automatic run_flush();
        int cycles;

        @(posedge aclk);
        flush_req <= 1'b1;
        cycles = 0;
        do begin
            @(posedge aclk);
            cycles++;
        end while (!flush_ack);
        // Request taken on the first edge, 64 erase cycles, ack seen one edge later
        compare("flush length in cycles", cycles, 1 + 64 + 1);
        repeat (3) begin
            @(posedge aclk);
            compare("flush_ack while flush_req high", flush_ack, 1);
        end
        flush_req <= 1'b0;
        @(posedge aclk);
        compare("flush_ack before flush_req is seen low", flush_ack, 1);
        @(posedge aclk);
        compare("flush_ack after release", flush_ack, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        seed_draw = $urandom(32'h053b50a8);
        aresetn    <= 1'b0;
        arvalid    <= 1'b0;
        araddr     <= '0;
        arprot     <= '0;
        rready     <= 1'b0;
        flush_req  <= 1'b0;
        generation <= 8'h01;
        load_table();
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (2) @(posedge aclk);
        foreach (rows[i]) begin
            generation <= rows[i].gen;
            if (rows[i].op == op_flush) begin
                run_flush();
            end else begin
                run_fetch(rows[i]);
            end
        end
        repeat (4) @(posedge aclk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // 200 cycles per row plus reset
    initial begin
        int limit;
        #1;
        limit = 200 * rows.size() + 20;
        repeat (limit) @(posedge aclk);
        $display("Timeout: the table did not complete within %0d clock cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
